// File: dv/led_assertions.sv
`timescale 1ns/1ps

module led_assertions (
	input logic                                       clk,
	input logic                                       rst,
	input logic                                       sft_shcp,
	input logic                                       sft_stcp,
	input logic                                       frame_vld,
	input logic                                       credit_rtn,
	input logic [$clog2(led_pkg::CREDITS+1)-1:0]      credit_cnt,
	output logic                                      failed
);

	logic       reset_bad  = 1'b0;
	logic       count_bad  = 1'b0;
	logic       credit_bad = 1'b0;
	logic [3:0] shcp_cnt;
	logic [$clog2(led_pkg::CREDITS+1):0] in_flight;

	assign failed = reset_bad || count_bad || credit_bad;

	// Shift clocks seen since the last latch
	always_ff @(posedge clk) begin
		if (rst || sft_stcp) begin
			shcp_cnt <= '0;
		end else if (sft_shcp) begin
			shcp_cnt <= shcp_cnt + 1'b1;
		end
	end

	// Frames on the link whose credit has not come back yet
	always_ff @(posedge clk) begin
		if (rst) begin
			in_flight <= '0;
		end else if (frame_vld && !credit_rtn) begin
			in_flight <= in_flight + 1'b1;
		end else if (credit_rtn && !frame_vld) begin
			in_flight <= in_flight - 1'b1;
		end
	end

	// ********************
	// Serial pins
	// ********************
	quiet_in_reset: assert property (@(posedge clk) rst && $past(rst) |-> !sft_shcp && !sft_stcp)
		else begin
			reset_bad = 1'b1;
			$error("Shift clock or latch active during reset");
		end

	eight_shifts: assert property (@(posedge clk) disable iff (rst) sft_stcp |-> shcp_cnt == 4'd8)
		else begin
			count_bad = 1'b1;
			$error("Latch pulse not preceded by exactly eight shift clocks");
		end

	// ********************
	// Credit counter
	// ********************
	credit_max: assert property (@(posedge clk) disable iff (rst)
		int'(credit_cnt) <= led_pkg::CREDITS)
		else begin
			credit_bad = 1'b1;
			$error("Credit count above the buffer depth");
		end

	credit_min: assert property (@(posedge clk) disable iff (rst)
		frame_vld |-> int'(in_flight) < led_pkg::CREDITS)
		else begin
			credit_bad = 1'b1;
			$error("Frame sent with no credit left");
		end

endmodule

// File: dv/led_tb.sv
`timescale 1ns/1ps

module led_tb;

	localparam int QUIET_CYCLES    = 3 * led_pkg::SHIFT_CYCLES; // Idle link after this
	localparam int FRAME_CYCLES    = led_pkg::SHIFT_CYCLES + 4;
	localparam int SPARK_CYCLES    = led_pkg::SPARK_TICKS * led_pkg::TICK_DIV;
	localparam int WATCHDOG_CYCLES = 40 * (SPARK_CYCLES + QUIET_CYCLES) + 160 * FRAME_CYCLES;

	logic                       clk;
	logic                       rst;
	logic                       wr_en;
	logic [reg_pkg::ADDR_W-1:0] wr_addr;
	logic [reg_pkg::DATA_W-1:0] wr_data;
	logic                       sft_shcp;
	logic                       sft_ds;
	logic                       sft_stcp;
	logic [7:0]                 shift_word;
	logic [7:0]                 frames [$];
	logic [31:0]                rng;

	led_top i_led_top (
		.clk      (clk),
		.rst      (rst),
		.wr_en    (wr_en),
		.wr_addr  (wr_addr),
		.wr_data  (wr_data),
		.sft_shcp (sft_shcp),
		.sft_ds   (sft_ds),
		.sft_stcp (sft_stcp)
	);

	bind led_top led_assertions i_led_assertions (
		.clk        (clk),
		.rst        (rst),
		.sft_shcp   (sft_shcp),
		.sft_stcp   (sft_stcp),
		.frame_vld  (frame_vld),
		.credit_rtn (credit_rtn),
		.credit_cnt (i_led_effect.credit_cnt),
		.failed     ()
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// ********************
	// Frame capture
	// ********************
	always @(negedge clk) begin
		if (sft_shcp) begin
			shift_word <= {shift_word[6:0], sft_ds}; // LED 7 arrives first
		end
		if (sft_stcp) begin
			frames.push_back(shift_word);
		end
	end

	always @(negedge clk) begin
		if (i_led_top.i_led_assertions.failed) begin
			$display("A bound protocol assertion on led_top failed");
			$display("TEST RESULT: FAIL");
			$fatal(1, "Protocol assertion failed");
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Timeout, the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST RESULT: FAIL");
		$fatal(1, "Watchdog expired");
	end

	function automatic logic [31:0] next_random(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	function automatic logic [reg_pkg::DATA_W-1:0] mode_word(input int led,
		input led_pkg::led_mode_e mode);
		logic [reg_pkg::DATA_W-1:0] w;
		w = '0;
		w[4*led +: 4] = mode;
		return w;
	endfunction

	function automatic logic [reg_pkg::DATA_W-1:0] onoff_word(input logic [7:0] pattern);
		logic [reg_pkg::DATA_W-1:0] w;
		w = '0;
		for (int i = 0; i < led_pkg::LED_COUNT; i++) begin
			w |= mode_word(i, pattern[i] ? led_pkg::MODE_ON : led_pkg::MODE_OFF);
		end
		return w;
	endfunction

	task automatic write_reg(input logic [reg_pkg::ADDR_W-1:0] addr,
		input logic [reg_pkg::DATA_W-1:0] data);
		@(negedge clk);
		wr_en   = 1'b1;
		wr_addr = addr;
		wr_data = data;
		@(negedge clk);
		wr_en   = 1'b0;
	endtask

	task automatic wait_frames(input int n);
		while (frames.size() < n) begin
			@(posedge clk);
		end
	endtask

	// Returns once no frame has been latched for a whole quiet window
	task automatic settle();
		int count;
		do begin
			count = frames.size();
			repeat (QUIET_CYCLES) @(posedge clk);
		end while (frames.size() != count);
	endtask

	task automatic check_equal(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		assert (expected == actual) else begin
			$display("Fail %s expected %0h actual %0h", name, expected, actual);
			$display("TEST RESULT: FAIL");
			$fatal(1, "Check %s failed", name);
		end
	endtask

	// Reads frames from first on until the LED has shown both values
	task automatic scan_toggle(input string name, input int first, input int led,
		input logic [7:0] others);
		int         idx;
		logic       seen_on;
		logic       seen_off;
		logic [7:0] keep;
		keep     = ~(8'h01 << led);
		seen_on  = 1'b0;
		seen_off = 1'b0;
		idx      = first;
		while (!(seen_on && seen_off) && idx < first + 64) begin
			wait_frames(idx + 1);
			check_equal(name, others, frames[idx] & keep);
			if (frames[idx][led]) begin
				seen_on = 1'b1;
			end else begin
				seen_off = 1'b1;
			end
			idx++;
		end
		check_equal(name, 8'h03, {6'd0, seen_on, seen_off});
	endtask

	initial begin
		int                         n0;
		logic [7:0]                 pattern;
		logic [reg_pkg::DATA_W-1:0] word;
		rst     = 1'b1;
		wr_en   = 1'b0;
		wr_addr = '0;
		wr_data = '0;
		rng     = 32'h33476b98;
		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		// Random OFF and ON words
		for (int k = 0; k < 6; k++) begin
			rng     = next_random(rng);
			pattern = rng[7:0];
			n0      = frames.size();
			write_reg(reg_pkg::ADDR_MODE, onoff_word(pattern));
			wait_frames(n0 + 1);
			settle();
			check_equal("random_onoff", pattern, frames[$]);
		end

		// One-shot spark on LED 1
		n0 = frames.size();
		write_reg(reg_pkg::ADDR_MODE, mode_word(1, led_pkg::MODE_SPARK));
		wait_frames(n0 + 1);
		check_equal("spark_on", 8'h02, frames[n0]);
		wait_frames(n0 + 2);
		check_equal("spark_off", 8'h00, frames[n0 + 1]);
		settle();
		check_equal("spark_once", 8'(n0 + 2), 8'(frames.size()));

		// Repeating spark on LED 0, LED 4 on
		n0 = frames.size();
		write_reg(reg_pkg::ADDR_MODE, mode_word(0, led_pkg::MODE_SPARK_REP) |
			mode_word(4, led_pkg::MODE_ON));
		for (int k = 0; k < 4; k++) begin
			wait_frames(n0 + k + 1);
			check_equal("spark_rep", 8'h10 | 8'(k & 1), frames[n0 + k]);
		end

		// Blink on LED 3, masked then enabled
		n0 = frames.size();
		write_reg(reg_pkg::ADDR_MODE, mode_word(3, led_pkg::MODE_BLING) |
			mode_word(6, led_pkg::MODE_ON));
		wait_frames(n0 + 1);
		settle();
		for (int i = n0; i < frames.size(); i++) begin
			check_equal("bling_masked", 8'h00, frames[i] & 8'h08);
		end
		check_equal("bling_masked", 8'h40, frames[$]);
		n0 = frames.size();
		write_reg(reg_pkg::ADDR_BLING, 32'h2); // Mask bit for LED 3
		scan_toggle("bling_enabled", n0, 3, 8'h40);

		// Breathing on LED 7 under back-pressure
		write_reg(reg_pkg::ADDR_MODE, '0);
		settle();
		n0 = frames.size();
		write_reg(reg_pkg::ADDR_BREATH, 32'h1);
		write_reg(reg_pkg::ADDR_MODE, mode_word(led_pkg::BREATH_LED, led_pkg::MODE_BREATH) |
			mode_word(0, led_pkg::MODE_ON) | mode_word(2, led_pkg::MODE_ON));
		scan_toggle("breath", n0, led_pkg::BREATH_LED, 8'h05);
		for (int k = 0; k < 8; k++) begin
			rng     = next_random(rng);
			pattern = rng[7:0];
			word    = onoff_word(pattern);
			if (k < 7) begin
				word[4*led_pkg::BREATH_LED +: 4] = led_pkg::MODE_BREATH;
			end
			write_reg(reg_pkg::ADDR_MODE, word);
		end
		settle();
		check_equal("burst_last", pattern, frames[$]);

		if (!i_led_top.i_led_assertions.failed) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			$display("TEST RESULT: FAIL");
			$fatal(1, "Protocol assertion failed");
		end
	end

endmodule

// File: list.f
logic/led_pkg.sv
logic/reg_pkg.sv
logic/led_cfg_if.sv
logic/led_regs.sv
logic/led_effect.sv
logic/led_shift.sv
logic/led_top.sv
dv/led_assertions.sv
dv/led_tb.sv

// File: logic/led_cfg_if.sv
`timescale 1ns/1ps

interface led_cfg_if;

	logic [4*led_pkg::LED_COUNT-1:0]                  modes;
	logic [7:0]                                       breath_period;
	logic [led_pkg::BLING_LAST-led_pkg::BLING_FIRST:0] bling_mask;
	logic                                             update; // Mode word just written
	logic [led_pkg::LED_COUNT-1:0]                    mode_changed;

	modport regs (
		output modes, breath_period, bling_mask, update, mode_changed
	);

	modport effect (
		input modes, breath_period, bling_mask, update, mode_changed
	);

endinterface

// File: logic/led_effect.sv
`timescale 1ns/1ps

module led_effect (
	input  logic                           clk,
	input  logic                           rst,
	led_cfg_if.effect                      cfg,
	output logic                           frame_vld,
	output logic [led_pkg::FRAME_BITS-1:0] frame,
	input  logic                           credit_rtn
);

	typedef logic [$clog2(led_pkg::TICK_DIV)-1:0]      tick_t;
	typedef logic [$clog2(led_pkg::SPARK_TICKS+1)-1:0] cnt_t;
	typedef logic [$clog2(led_pkg::CREDITS+1)-1:0]     credit_t;

	led_pkg::led_mode_e            mode [led_pkg::LED_COUNT];
	cnt_t                          cnt [led_pkg::LED_COUNT];
	logic [led_pkg::LED_COUNT-1:0] evt;
	logic [led_pkg::LED_COUNT-1:0] led_q;
	logic [led_pkg::LED_COUNT-1:0] led_d;
	tick_t                         tick_cnt;
	logic                          tick;
	logic [7:0]                    breath_cnt;
	logic [7:0]                    breath_round;
	logic                          breath_dir;
	logic                          breath_evt;
	logic                          breath_on;
	logic                          led_load;
	logic                          pending;
	logic                          send;
	credit_t                       credit_cnt;

	// ********************
	// Tick prescaler
	// ********************
	assign tick = (tick_cnt == tick_t'(led_pkg::TICK_DIV - 1));

	always_ff @(posedge clk) begin
		if (rst || tick) begin
			tick_cnt <= '0;
		end else begin
			tick_cnt <= tick_cnt + 1'b1;
		end
	end

	// ********************
	// Per-LED phase counters
	// ********************
	for (genvar n = 0; n < led_pkg::LED_COUNT; n++) begin : g_led
		logic is_spark;
		logic is_bling;
		logic bling_en;
		logic adv;

		assign mode[n]  = led_pkg::led_mode_e'(cfg.modes[4*n +: 4]);
		assign is_spark = (mode[n] == led_pkg::MODE_SPARK) ||
			(mode[n] == led_pkg::MODE_SPARK_REP);

		if (n >= led_pkg::BLING_FIRST && n <= led_pkg::BLING_LAST) begin : g_bling
			assign is_bling = (mode[n] == led_pkg::MODE_BLING);
			assign bling_en = cfg.bling_mask[n - led_pkg::BLING_FIRST];
		end else begin : g_fixed
			assign is_bling = 1'b0;
			assign bling_en = 1'b0;
		end

		// Blink steps only count on enabled ticks
		assign adv    = tick && (cnt[n] != '0) && (is_spark || (is_bling && bling_en));
		assign evt[n] = adv && (cnt[n] == (is_bling ? cnt_t'(led_pkg::BLING_STEPS) :
			cnt_t'(led_pkg::SPARK_TICKS)));

		always_ff @(posedge clk) begin
			if (rst) begin
				cnt[n] <= '0;
			end else if (cfg.update) begin
				if (mode[n] == led_pkg::MODE_OFF || mode[n] == led_pkg::MODE_ON) begin
					cnt[n] <= '0;
				end else if (mode[n] == led_pkg::MODE_SPARK || (cfg.mode_changed[n] &&
					(mode[n] == led_pkg::MODE_SPARK_REP || is_bling))) begin
					cnt[n] <= cnt_t'(1); // Unchanged repeat keeps its phase
				end
			end else if (evt[n]) begin
				cnt[n] <= (mode[n] == led_pkg::MODE_SPARK) ? '0 : cnt_t'(1);
			end else if (adv) begin
				cnt[n] <= cnt[n] + 1'b1;
			end
		end
	end

	// ********************
	// Breathing on LED 7
	// ********************
	assign breath_evt = tick && (mode[led_pkg::BREATH_LED] == led_pkg::MODE_BREATH);
	assign breath_on  = breath_dir ? (breath_cnt < breath_round) : (breath_cnt >= breath_round);

	always_ff @(posedge clk) begin
		if (rst || (cfg.update && mode[led_pkg::BREATH_LED] != led_pkg::MODE_BREATH)) begin
			breath_cnt   <= '0;
			breath_round <= '0;
			breath_dir   <= 1'b0;
		end else if (breath_evt) begin
			if (breath_cnt != cfg.breath_period) begin
				breath_cnt <= breath_cnt + 1'b1; // Step within one PWM round
			end else begin
				breath_cnt <= '0;
				if (breath_round != cfg.breath_period) begin
					breath_round <= breath_round + 1'b1;
				end else begin
					breath_round <= '0;
					breath_dir   <= ~breath_dir; // Swap fade direction
				end
			end
		end
	end

	// LED register, mode writes take priority over effects
	always_comb begin
		led_d = led_q;
		for (int i = 0; i < led_pkg::LED_COUNT; i++) begin
			if (cfg.update) begin
				case (mode[i])
					led_pkg::MODE_OFF:                     led_d[i] = 1'b0;
					led_pkg::MODE_ON, led_pkg::MODE_SPARK: led_d[i] = 1'b1;
					default:                               led_d[i] = led_q[i];
				endcase
			end else if (i == led_pkg::BREATH_LED && breath_evt) begin
				led_d[i] = breath_on;
			end else if (evt[i]) begin
				led_d[i] = ~led_q[i];
			end
		end
	end

	assign led_load = cfg.update || breath_evt || (|evt);

	always_ff @(posedge clk) begin
		if (rst) begin
			led_q <= '0;
		end else if (led_load) begin
			led_q <= led_d;
		end
	end

	// ********************
	// Credit sender
	// ********************
	assign send = pending && (credit_cnt != '0);

	always_ff @(posedge clk) begin
		if (rst) begin
			pending    <= 1'b0;
			frame_vld  <= 1'b0;
			credit_cnt <= credit_t'(led_pkg::CREDITS);
		end else begin
			pending   <= led_load || (pending && !send); // Coalesces waiting frames
			frame_vld <= send;
			if (send && !credit_rtn) begin
				credit_cnt <= credit_cnt - 1'b1;
			end else if (credit_rtn && !send) begin
				credit_cnt <= credit_cnt + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (send) begin
			frame <= led_q;
		end
	end

endmodule

// File: logic/led_pkg.sv
package led_pkg;

	// ********************
	// LED modes
	// ********************
	typedef enum logic [3:0] {
		MODE_OFF       = 4'd0,
		MODE_ON        = 4'd1,
		MODE_SPARK     = 4'd2, // One-shot
		MODE_SPARK_REP = 4'd3, // Repeating
		MODE_BLING     = 4'd4, // Stepped blink on LEDs 2 to 5
		MODE_BREATH    = 4'd5  // LED 7 only
	} led_mode_e;

	localparam int LED_COUNT = 8;

	// Effect timing in ticks, scaled down for simulation
	localparam int TICK_DIV    = 4; // Clocks per tick
	localparam int SPARK_TICKS = 6;
	localparam int BLING_STEPS = 2;

	localparam int BREATH_LED  = 7;
	localparam int BLING_FIRST = 2;
	localparam int BLING_LAST  = 5;

	// Frame link and serializer
	localparam int CREDITS      = 2;
	localparam int FRAME_BITS   = 8;
	localparam int SHIFT_CYCLES = 17; // 8 two-cycle slots plus latch

endpackage

// File: logic/led_regs.sv
`timescale 1ns/1ps

module led_regs (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wr_en,
	input  logic [reg_pkg::ADDR_W-1:0] wr_addr,
	input  logic [reg_pkg::DATA_W-1:0] wr_data,
	led_cfg_if.regs                    cfg
);

	logic [led_pkg::LED_COUNT-1:0] diff;

	// Compare the incoming word against the stored one, field by field
	always_comb begin
		for (int i = 0; i < led_pkg::LED_COUNT; i++) begin
			diff[i] = (wr_data[4*i +: 4] != cfg.modes[4*i +: 4]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			cfg.modes         <= '0;
			cfg.breath_period <= '0;
			cfg.bling_mask    <= '0;
			cfg.update        <= 1'b0;
			cfg.mode_changed  <= '0;
		end else begin
			cfg.update       <= 1'b0;
			cfg.mode_changed <= '0;
			if (wr_en) begin
				case (wr_addr)
					reg_pkg::ADDR_MODE: begin
						cfg.modes        <= wr_data[4*led_pkg::LED_COUNT-1:0];
						cfg.update       <= 1'b1;
						cfg.mode_changed <= diff;
					end
					reg_pkg::ADDR_BREATH: begin
						cfg.breath_period <= wr_data[7:0];
					end
					reg_pkg::ADDR_BLING: begin
						cfg.bling_mask <= wr_data[$bits(cfg.bling_mask)-1:0];
					end
					default: ; // Unknown address, ignored
				endcase
			end
		end
	end

endmodule

// File: logic/led_shift.sv
`timescale 1ns/1ps

module led_shift (
	input  logic                           clk,
	input  logic                           rst,
	input  logic                           frame_vld,
	input  logic [led_pkg::FRAME_BITS-1:0] frame,
	output logic                           credit_rtn,
	output logic                           sft_shcp,
	output logic                           sft_ds,
	output logic                           sft_stcp
);

	typedef logic [$clog2(led_pkg::SHIFT_CYCLES)-1:0] phase_t;
	typedef logic [$clog2(led_pkg::CREDITS)-1:0]      ptr_t;
	typedef logic [$clog2(led_pkg::CREDITS+1)-1:0]    count_t;

	logic [led_pkg::FRAME_BITS-1:0] buf_mem [led_pkg::CREDITS];
	ptr_t                           wr_ptr;
	ptr_t                           rd_ptr;
	count_t                         buf_cnt;
	logic                           buf_empty;
	logic                           push;
	logic                           pop;
	logic                           start;
	logic                           busy;
	logic                           last;
	phase_t                         phase;
	logic [led_pkg::FRAME_BITS-1:0] shreg;

	// ********************
	// Frame buffer
	// ********************
	assign buf_empty = (buf_cnt == '0);
	assign last      = busy && (phase == phase_t'(led_pkg::SHIFT_CYCLES - 1));
	assign start     = (!busy || last) && (!buf_empty || frame_vld);
	assign pop       = start && !buf_empty;
	assign push      = frame_vld && !(start && buf_empty); // Bypass when nothing waits

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr  <= '0;
			rd_ptr  <= '0;
			buf_cnt <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_t'(led_pkg::CREDITS - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_t'(led_pkg::CREDITS - 1)) ? '0 : rd_ptr + 1'b1;
			end
			case ({push, pop})
				2'b10:   buf_cnt <= buf_cnt + 1'b1;
				2'b01:   buf_cnt <= buf_cnt - 1'b1;
				default: buf_cnt <= buf_cnt;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (push) begin
			buf_mem[wr_ptr] <= frame;
		end
	end

	// ********************
	// Serializer
	// ********************
	always_ff @(posedge clk) begin
		if (rst) begin
			busy       <= 1'b0;
			phase      <= '0;
			credit_rtn <= 1'b0;
		end else begin
			credit_rtn <= last; // Frame fully latched
			if (start) begin
				busy  <= 1'b1;
				phase <= '0;
			end else if (last) begin
				busy <= 1'b0;
			end else if (busy) begin
				phase <= phase + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			shreg <= buf_empty ? frame : buf_mem[rd_ptr];
		end else if (busy && phase[0]) begin
			shreg <= shreg << 1; // Next bit after the clock edge
		end
	end

	assign sft_ds   = busy && shreg[led_pkg::FRAME_BITS-1];
	assign sft_shcp = busy && phase[0]; // Second cycle of each slot
	assign sft_stcp = last;

endmodule

// File: logic/led_top.sv
`timescale 1ns/1ps

module led_top (
	input  logic                       clk,
	input  logic                       rst,
	input  logic                       wr_en,
	input  logic [reg_pkg::ADDR_W-1:0] wr_addr,
	input  logic [reg_pkg::DATA_W-1:0] wr_data,
	output logic                       sft_shcp,
	output logic                       sft_ds,
	output logic                       sft_stcp
);

	logic                           frame_vld;
	logic [led_pkg::FRAME_BITS-1:0] frame;
	logic                           credit_rtn;

	led_cfg_if cfg ();

	// ********************
	// Register block
	// ********************
	led_regs i_led_regs (
		.clk     (clk),
		.rst     (rst),
		.wr_en   (wr_en),
		.wr_addr (wr_addr),
		.wr_data (wr_data),
		.cfg     (cfg.regs)
	);

	// ********************
	// Effects and frame link
	// ********************
	led_effect i_led_effect (
		.clk        (clk),
		.rst        (rst),
		.cfg        (cfg.effect),
		.frame_vld  (frame_vld),
		.frame      (frame),
		.credit_rtn (credit_rtn)
	);

	led_shift i_led_shift (
		.clk        (clk),
		.rst        (rst),
		.frame_vld  (frame_vld),
		.frame      (frame),
		.credit_rtn (credit_rtn),
		.sft_shcp   (sft_shcp),
		.sft_ds     (sft_ds),
		.sft_stcp   (sft_stcp)
	);

endmodule

// File: logic/reg_pkg.sv
package reg_pkg;

	localparam int ADDR_W = 2;
	localparam int DATA_W = 32;

	// ********************
	// Register map
	// ********************
	localparam logic [ADDR_W-1:0] ADDR_MODE   = 2'd0; // 4-bit field per LED
	localparam logic [ADDR_W-1:0] ADDR_BREATH = 2'd1; // 8-bit period
	localparam logic [ADDR_W-1:0] ADDR_BLING  = 2'd2; // Mask for LEDs 2 to 5

endpackage

// File: run.sh
#!/bin/sh
# Build and run the LED controller testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module led_tb -f list.f -o led_sim

# Keep running after an assertion error so the testbench can report it
out=$(./obj_dir/led_sim +verilator+error+limit+100 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "TEST RESULT: PASS"; then
	exit 0
fi
exit 1
